//--- common/fetch_pkg.sv
// fetch-side types; XLEN is both data and byte-address width, responses use AXI-style codes
package fetch_pkg;

	// word and address width
	localparam int XLEN = 32;

	// fetch controller states
	typedef enum logic [1:0] {
		WAIT_ADDR,
		WAIT_DATA,
		PRESENT,
		WAIT_RETIRE
	} fetch_state_e;

	// read response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

endpackage

//--- common/rv_isa_pkg.sv
// RV32I base encodings only; no compressed, M, A or F extensions, and no FENCE or CSRRC group
package rv_isa_pkg;

	// major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// load widths
	typedef enum logic [2:0] {
		F3_LB  = 3'b000,
		F3_LH  = 3'b001,
		F3_LW  = 3'b010,
		F3_LBU = 3'b100,
		F3_LHU = 3'b101
	} load_f3_e;

	// store widths
	typedef enum logic [2:0] {
		F3_SB = 3'b000,
		F3_SH = 3'b001,
		F3_SW = 3'b010
	} store_f3_e;

	// immediate alu group, all eight codes are defined
	typedef enum logic [2:0] {
		F3_ADDI      = 3'b000,
		F3_SLLI      = 3'b001,
		F3_SLTI      = 3'b010,
		F3_SLTIU     = 3'b011,
		F3_XORI      = 3'b100,
		F3_SRLI_SRAI = 3'b101,
		F3_ORI       = 3'b110,
		F3_ANDI      = 3'b111
	} imm_f3_e;

	// csr accesses handled by the core
	typedef enum logic [2:0] {
		F3_CSRRW = 3'b001,
		F3_CSRRS = 3'b010
	} csr_f3_e;

	// system words with funct3 of zero, matched whole
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

	// funct7 of immediate shifts
	localparam logic [6:0] SHIFT_F7_LOGIC = 7'b000_0000;
	localparam logic [6:0] SHIFT_F7_ARITH = 7'b010_0000;

endpackage

//--- common/imem_rd_if.sv
// one read in flight at a time; slave holds r_* until r_ready, master holds ar_* until ar_ready
interface imem_rd_if import fetch_pkg::*; ();

	// read-address channel
	logic            ar_valid;
	logic            ar_ready;
	logic [XLEN-1:0] ar_addr;

	// read-data channel
	logic            r_valid;
	logic            r_ready;
	logic [XLEN-1:0] r_data;
	resp_e           r_resp;

	modport master (
		output ar_valid,
		output ar_addr,
		output r_ready,
		input  ar_ready,
		input  r_valid,
		input  r_data,
		input  r_resp
	);

	modport slave (
		input  ar_valid,
		input  ar_addr,
		input  r_ready,
		output ar_ready,
		output r_valid,
		output r_data,
		output r_resp
	);

endinterface

//--- ifu/ifu_ctrl.sv
// single fetch in flight; retire_i is only sampled in WAIT_RETIRE, error beats are still presented
module ifu_ctrl import fetch_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            retire_i,
	input  logic [XLEN-1:0] pc_i,
	imem_rd_if.master       rd,
	output logic            advance_o,
	output logic            fetch_valid_o,
	output logic [XLEN-1:0] inst_o,
	output logic            fetch_err_o
);

	fetch_state_e    state_q;
	fetch_state_e    state_d;
	logic            ar_fire;
	logic            r_fire;
	logic [XLEN-1:0] inst_q;
	logic            err_q;

	// channel controls come straight from the state
	assign rd.ar_valid = (state_q == WAIT_ADDR);
	assign rd.ar_addr  = pc_i;
	assign rd.r_ready  = (state_q == WAIT_DATA);

	assign ar_fire = rd.ar_valid && rd.ar_ready;
	assign r_fire  = rd.r_valid && rd.r_ready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			WAIT_ADDR: begin
				if (ar_fire) begin
					state_d = WAIT_DATA;
				end
			end
			WAIT_DATA: begin
				// error or not, the beat ends the read
				if (r_fire) begin
					state_d = PRESENT;
				end
			end
			PRESENT: begin
				state_d = WAIT_RETIRE;
			end
			WAIT_RETIRE: begin
				if (retire_i) begin
					state_d = WAIT_ADDR;
				end
			end
			default: begin
				state_d = WAIT_ADDR;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= WAIT_ADDR;
		end else begin
			state_q <= state_d;
		end
	end

	// word and error flag held until the next beat
	always_ff @(posedge clk_i) begin
		if (r_fire) begin
			inst_q <= rd.r_data;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			err_q <= 1'b0;
		end else if (r_fire) begin
			err_q <= (rd.r_resp == SLVERR);
		end
	end

	assign fetch_valid_o = (state_q == PRESENT);
	assign advance_o     = (state_q == WAIT_RETIRE) && retire_i;
	assign inst_o        = inst_q;
	assign fetch_err_o   = err_q;

	// pc from pc_counter must not move under a pending request
	a_ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		rd.ar_valid && !rd.ar_ready |=> rd.ar_valid && $stable(rd.ar_addr));

	a_valid_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		fetch_valid_o |=> !fetch_valid_o);

endmodule

//--- ifu/pc_counter.sv
// pc moves only on advance_i; redirect targets are assumed word-aligned by the caller
module pc_counter import fetch_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            advance_i,
	input  logic            branch_req_i,
	input  logic            branch_taken_i,
	input  logic [XLEN-1:0] branch_target_i,
	input  logic            jmp_i,
	input  logic [XLEN-1:0] jmp_target_i,
	input  logic            trap_i,
	input  logic [XLEN-1:0] trap_target_i,
	output logic [XLEN-1:0] pc_o
);

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] pc_seq;
	logic [XLEN-1:0] pc_next;

	assign pc_seq = pc_q + XLEN'(4);

	// trap beats jump beats taken branch
	always_comb begin
		if (trap_i) begin
			pc_next = trap_target_i;
		end else if (jmp_i) begin
			pc_next = jmp_target_i;
		end else if (branch_req_i && branch_taken_i) begin
			pc_next = branch_target_i;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc_q <= RESET_PC;
		end else if (advance_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

	a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
		pc_o[1:0] == 2'b00);

endmodule

//--- ifu/inst_checker.sv
// flags words outside the supported RV32I subset; any branch funct3 and any OP word pass
module inst_checker import fetch_pkg::*; import rv_isa_pkg::*; (
	input  logic [XLEN-1:0] inst_i,
	output logic            illegal_o
);

	localparam logic [2:0] JALR_F3 = 3'b000;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       illegal;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		illegal = 1'b1;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_BRANCH, OPC_OP: begin
				illegal = 1'b0;
			end
			OPC_JALR: begin
				illegal = (funct3 != JALR_F3);
			end
			OPC_LOAD: begin
				// ld and lwu are rv64 only
				case (load_f3_e'(funct3))
					F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: illegal = 1'b0;
					default: illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				case (store_f3_e'(funct3))
					F3_SB, F3_SH, F3_SW: illegal = 1'b0;
					default: illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				// shifts restrict funct7, the rest take any immediate
				case (imm_f3_e'(funct3))
					F3_SLLI: begin
						illegal = (funct7 != SHIFT_F7_LOGIC);
					end
					F3_SRLI_SRAI: begin
						illegal = !((funct7 == SHIFT_F7_LOGIC) ||
							(funct7 == SHIFT_F7_ARITH));
					end
					default: illegal = 1'b0;
				endcase
			end
			OPC_SYSTEM: begin
				case (csr_f3_e'(funct3))
					F3_CSRRW, F3_CSRRS: begin
						illegal = 1'b0;
					end
					default: begin
						// ecall, ebreak and mret must match exactly
						illegal = !((inst_i == INST_ECALL) ||
							(inst_i == INST_EBREAK) ||
							(inst_i == INST_MRET));
					end
				endcase
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	assign illegal_o = illegal;

endmodule

//--- logic/imem_slave.sv
// byte addresses with the low two bits ignored; IMEM_DEPTH >= 2, IMEM_LATENCY >= 1; data sampled at accept
module imem_slave import fetch_pkg::*; #(
	parameter int IMEM_DEPTH   = 256,
	parameter int IMEM_LATENCY = 2
) (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            load_we_i,
	input  logic [XLEN-1:0] load_addr_i,
	input  logic [XLEN-1:0] load_data_i,
	imem_rd_if.slave        rd
);

	localparam int IDX_W = $clog2(IMEM_DEPTH);
	localparam int CNT_W = $clog2(IMEM_LATENCY + 1);

	logic [XLEN-1:0]  mem [IMEM_DEPTH];
	logic             busy_q;
	logic [CNT_W-1:0] cnt_q;
	logic [XLEN-1:0]  data_q;
	resp_e            resp_q;
	logic             ar_fire;
	logic             r_fire;
	logic             rd_in_range;
	logic             load_in_range;

	assign rd_in_range   = rd.ar_addr[XLEN-1:2] < (XLEN-2)'(IMEM_DEPTH);
	assign load_in_range = load_addr_i[XLEN-1:2] < (XLEN-2)'(IMEM_DEPTH);

	// writes beyond the array are dropped
	always_ff @(posedge clk_i) begin
		if (load_we_i && load_in_range) begin
			mem[load_addr_i[IDX_W+1:2]] <= load_data_i;
		end
	end

	assign ar_fire = rd.ar_valid && rd.ar_ready;
	assign r_fire  = rd.r_valid && rd.r_ready;

	// latency count starts at the accept edge
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (ar_fire) begin
			busy_q <= 1'b1;
			cnt_q  <= CNT_W'(IMEM_LATENCY - 1);
		end else if (r_fire) begin
			busy_q <= 1'b0;
		end else if (busy_q && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// out of range gives zero data and slverr
	always_ff @(posedge clk_i) begin
		if (ar_fire) begin
			data_q <= rd_in_range ? mem[rd.ar_addr[IDX_W+1:2]] : '0;
			resp_q <= rd_in_range ? OKAY : SLVERR;
		end
	end

	assign rd.ar_ready = !busy_q;
	assign rd.r_valid  = busy_q && (cnt_q == '0);
	assign rd.r_data   = data_q;
	assign rd.r_resp   = resp_q;

	// data only ever appears a fixed latency after an accepted address
	a_rvalid_origin: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(rd.r_valid) |-> $past(rd.ar_valid && rd.ar_ready, IMEM_LATENCY));

endmodule

//--- logic/fetch_top.sv
// fetch stage with its own instruction memory; redirect inputs only count on the retire cycle
module fetch_top import fetch_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC     = '0,
	parameter int              IMEM_DEPTH   = 256,
	parameter int              IMEM_LATENCY = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            branch_req_i,
	input  logic            branch_taken_i,
	input  logic [XLEN-1:0] branch_target_i,
	input  logic            jmp_i,
	input  logic [XLEN-1:0] jmp_target_i,
	input  logic            trap_i,
	input  logic [XLEN-1:0] trap_target_i,
	input  logic            retire_i,
	input  logic            load_we_i,
	input  logic [XLEN-1:0] load_addr_i,
	input  logic [XLEN-1:0] load_data_i,
	output logic            fetch_valid_o,
	output logic [XLEN-1:0] fetch_inst_o,
	output logic [XLEN-1:0] fetch_pc_o,
	output logic            inst_illegal_o,
	output logic            fetch_err_o
);

	logic            advance;
	logic [XLEN-1:0] pc;

	imem_rd_if rd_bus ();

	ifu_ctrl u_ifu_ctrl (
		.clk_i         (clk),
		.rst_i         (rst),
		.retire_i      (retire_i),
		.pc_i          (pc),
		.rd            (rd_bus.master),
		.advance_o     (advance),
		.fetch_valid_o (fetch_valid_o),
		.inst_o        (fetch_inst_o),
		.fetch_err_o   (fetch_err_o)
	);

	pc_counter #(
		.RESET_PC (RESET_PC)
	) u_pc_counter (
		.clk_i           (clk),
		.rst_i           (rst),
		.advance_i       (advance),
		.branch_req_i    (branch_req_i),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i),
		.jmp_i           (jmp_i),
		.jmp_target_i    (jmp_target_i),
		.trap_i          (trap_i),
		.trap_target_i   (trap_target_i),
		.pc_o            (pc)
	);

	// checks the held word, so it is stable while waiting for retire
	inst_checker u_inst_checker (
		.inst_i    (fetch_inst_o),
		.illegal_o (inst_illegal_o)
	);

	imem_slave #(
		.IMEM_DEPTH   (IMEM_DEPTH),
		.IMEM_LATENCY (IMEM_LATENCY)
	) u_imem_slave (
		.clk_i       (clk),
		.rst_i       (rst),
		.load_we_i   (load_we_i),
		.load_addr_i (load_addr_i),
		.load_data_i (load_data_i),
		.rd          (rd_bus.slave)
	);

	assign fetch_pc_o = pc;

endmodule

//--- dv/tb_clk_gen.sv
// free-running testbench clock, starts low; PERIOD should be even
module tb_clk_gen #(
	parameter int PERIOD = 4
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule

//--- dv/fetch_tb.sv
// IMEM_DEPTH 64, latency 2; memory loading runs past reset and the first retire waits for it
module fetch_tb import fetch_pkg::*; import rv_isa_pkg::*; ();

	localparam logic [XLEN-1:0] RESET_PC = '0;
	localparam int DEPTH     = 64;
	localparam int LATENCY   = 2;
	localparam int VEC_BASE  = 40;
	localparam int N_VEC     = 14;
	localparam int N_FETCH   = 55;
	localparam int HOLD_WAIT = 10;
	// twice the loading and every fetch with its latency, retire wait and hold time
	localparam int WDOG_CYC  = 2 * (DEPTH + N_VEC + N_FETCH * (LATENCY + 8 + HOLD_WAIT));

	// bit 32 set for words that must be flagged illegal
	localparam logic [32:0] VECS [N_VEC] = '{
		{1'b0, 32'h0000_12b7},
		{1'b0, 32'h0000_8067},
		{1'b0, 32'h0020_8463},
		{1'b0, 32'h0000_a103},
		{1'b0, 32'h0020_a023},
		{1'b0, 32'h4010_d093},
		{1'b0, 32'h0020_81b3},
		{1'b0, 32'h3000_22f3},
		{1'b0, INST_MRET},
		{1'b1, 32'h0000_b103},	// ld
		{1'b1, 32'h4010_9093},
		{1'b1, 32'h3000_32f3},	// csrrc
		{1'b1, 32'h0000_0000},
		{1'b1, 32'h0ff0_000f}
	};

	logic            clk, rst, retire, load_we;
	logic            branch_req, branch_taken, jmp, trap;
	logic [XLEN-1:0] branch_target, jmp_target, trap_target, load_addr, load_data;
	logic            fetch_valid, fetch_err, inst_illegal;
	logic [XLEN-1:0] fetch_inst, fetch_pc;

	// reference model of memory contents and the expected fetch
	logic [XLEN-1:0] model_mem [DEPTH];
	logic            model_illegal [DEPTH];
	logic [XLEN-1:0] exp_pc, exp_inst;
	logic            exp_err, exp_illegal, check_legal, holding;
	int              seed, errors, test_errors, failed_tests;
	string           test_name;

	tb_clk_gen #(.PERIOD(4)) u_clk_gen (.clk_o(clk));

	fetch_top #(
		.RESET_PC     (RESET_PC),
		.IMEM_DEPTH   (DEPTH),
		.IMEM_LATENCY (LATENCY)
	) dut (
		.clk             (clk),
		.rst             (rst),
		.branch_req_i    (branch_req),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.jmp_i           (jmp),
		.jmp_target_i    (jmp_target),
		.trap_i          (trap),
		.trap_target_i   (trap_target),
		.retire_i        (retire),
		.load_we_i       (load_we),
		.load_addr_i     (load_addr),
		.load_data_i     (load_data),
		.fetch_valid_o   (fetch_valid),
		.fetch_inst_o    (fetch_inst),
		.fetch_pc_o      (fetch_pc),
		.inst_illegal_o  (inst_illegal),
		.fetch_err_o     (fetch_err)
	);

	always_comb begin
		exp_err     = (exp_pc[XLEN-1:2] >= 30'(DEPTH));
		exp_inst    = exp_err ? '0 : model_mem[exp_pc[7:2]];
		exp_illegal = model_illegal[exp_pc[7:2]];
		check_legal = !exp_err && (exp_pc[7:2] >= 6'(VEC_BASE)) &&
			(exp_pc[7:2] < 6'(VEC_BASE + N_VEC));
	end

	a_fetch: assert property (@(posedge clk) disable iff (rst)
		fetch_valid |-> fetch_pc == exp_pc && fetch_inst == exp_inst && fetch_err == exp_err)
	else begin
		errors++;
		$display("[ERROR] %s: pc/inst/err expected %h %h %b actual %h %h %b", test_name,
			$sampled(exp_pc), $sampled(exp_inst), $sampled(exp_err),
			$sampled(fetch_pc), $sampled(fetch_inst), $sampled(fetch_err));
	end

	a_illegal: assert property (@(posedge clk) disable iff (rst)
		fetch_valid && check_legal |-> inst_illegal == exp_illegal)
	else begin
		errors++;
		$display("[ERROR] %s: illegal at pc %h expected %b actual %b", test_name,
			$sampled(exp_pc), $sampled(exp_illegal), $sampled(inst_illegal));
	end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		holding |=> $stable(fetch_pc) && $stable(fetch_inst) && $stable(fetch_err))
	else begin
		errors++;
		$display("%s: fetch outputs changed while waiting for retire", test_name);
	end

	a_single: assert property (@(posedge clk) disable iff (rst) holding |-> !fetch_valid)
	else begin
		errors++;
		$display("%s: second fetch_valid_o pulse without a retire", test_name);
	end

	function automatic logic [XLEN-1:0] rand_target();
		logic [31:0] r;
		r = $random(seed);
		return {24'd0, r[5:0], 2'b00};
	endfunction

	task automatic load_memory();
		logic [XLEN-1:0] w;
		int              idx;
		// random fill of every word, then the legality vectors on top
		for (int i = 0; i < DEPTH + N_VEC; i++) begin
			@(posedge clk);
			idx = (i < DEPTH) ? i : VEC_BASE + i - DEPTH;
			w = (i < DEPTH) ? $random(seed) : VECS[i-DEPTH][31:0];
			model_mem[idx] = w;
			model_illegal[idx] = (i < DEPTH) ? 1'b0 : VECS[i-DEPTH][32];
			load_we   <= 1'b1;
			load_addr <= 32'(idx) << 2;
			load_data <= w;
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic clear_redirects();
		trap          <= 1'b0;
		jmp           <= 1'b0;
		branch_req    <= 1'b0;
		branch_taken  <= 1'b0;
		trap_target   <= '0;
		jmp_target    <= '0;
		branch_target <= '0;
	endtask

	task automatic wait_fetch();
		do begin
			@(negedge clk);
		end while (!fetch_valid);
		@(posedge clk);
		holding <= 1'b1;
	endtask

	task automatic retire_with(input logic tr, input logic jp, input logic br, input logic tk,
		input logic [XLEN-1:0] tt, input logic [XLEN-1:0] jt, input logic [XLEN-1:0] bt);
		@(posedge clk);
		holding       <= 1'b0;
		retire        <= 1'b1;
		trap          <= tr;
		jmp           <= jp;
		branch_req    <= br;
		branch_taken  <= tk;
		trap_target   <= tt;
		jmp_target    <= jt;
		branch_target <= bt;
		// trap, then jump, then taken branch, else sequential
		if (tr)
			exp_pc = tt;
		else if (jp)
			exp_pc = jt;
		else if (br && tk)
			exp_pc = bt;
		else
			exp_pc = exp_pc + 32'd4;
		@(posedge clk);
		retire <= 1'b0;
		clear_redirects();
	endtask

	task automatic retire_seq();
		retire_with(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
	endtask

	// redirects wiggle for a while with retire low
	task automatic toggle_redirects();
		logic [31:0] r;
		repeat (HOLD_WAIT) begin
			@(posedge clk);
			r = $random(seed);
			trap          <= r[0];
			jmp           <= r[1];
			branch_req    <= r[2];
			branch_taken  <= r[3];
			trap_target   <= rand_target();
			jmp_target    <= rand_target();
			branch_target <= rand_target();
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		@(negedge clk);
		if (errors != test_errors)
			failed_tests++;
		$display("test %s done, %0d errors", test_name, errors - test_errors);
	endtask

	initial begin
		logic [31:0] r;
		seed = 32'h5afd_127c;
		errors = 0;
		failed_tests = 0;
		holding = 1'b0;
		exp_pc = RESET_PC;
		rst = 1'b1;
		retire = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		clear_redirects();

		start_test("reset_seq");
		fork
			begin
				repeat (8) @(posedge clk);
				rst <= 1'b0;
				wait_fetch();
			end
			load_memory();
		join
		repeat (8) begin
			retire_seq();
			wait_fetch();
		end
		end_test();

		start_test("redirect");
		repeat (20) begin
			r = $random(seed);
			retire_with(r[0], r[1], r[2], r[3], rand_target(), rand_target(), rand_target());
			wait_fetch();
		end
		end_test();

		start_test("legality");
		retire_with(1'b0, 1'b1, 1'b0, 1'b0, '0, 32'(VEC_BASE * 4), '0);
		wait_fetch();
		repeat (N_VEC - 1) begin
			retire_seq();
			wait_fetch();
		end
		end_test();

		start_test("fetch_err");
		retire_with(1'b0, 1'b1, 1'b0, 1'b0, '0, 32'(DEPTH * 4), '0);
		wait_fetch();
		retire_seq();
		wait_fetch();
		end_test();

		start_test("hold");
		retire_with(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0);
		repeat (4) begin
			wait_fetch();
			toggle_redirects();
			retire_seq();
		end
		wait_fetch();
		end_test();

		$display("tests run 5, tests failed %0d, errors %0d", failed_tests, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WDOG_CYC) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WDOG_CYC);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- fetch_sub.f
common/fetch_pkg.sv
common/rv_isa_pkg.sv
common/imem_rd_if.sv
ifu/ifu_ctrl.sv
ifu/pc_counter.sv
ifu/inst_checker.sv
logic/imem_slave.sv
logic/fetch_top.sv
dv/tb_clk_gen.sv
dv/fetch_tb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f fetch_sub.f -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -q '>>> FAIL' sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
